// File: angle_interp.sv
module angle_interp import hall_pkg::*, rotor_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  commutation_t comm,
    input  speed_t       speed,
    input  position_t    position,
    output rotor_state_t rotor
);

    acc_t    acc_q;
    acc_t    acc_d;
    acc_t    acc_sum;
    acc_t    acc_left;
    acc_t    acc_period;
    offset_t offset_q;
    offset_t offset_d;
    angle_t  angle_q;
    angle_t  sector_base;
    logic    interp_on;
    logic    at_limit;

    assign interp_on   = comm.known && !comm.fault && !speed.stalled;
    assign acc_period  = acc_t'(speed.period);
    assign acc_sum     = acc_q + acc_t'(SECTOR_SPAN);
    assign acc_left    = acc_sum - acc_period;
    assign at_limit    = comm.dir_fwd ? (offset_q == OFFSET_LAST) : (offset_q == '0);
    assign sector_base = angle_t'(comm.sector) * angle_t'(SECTOR_SPAN);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Rate accumulator
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // SECTOR_SPAN per clock against period gives span/period counts per clock
    always_comb begin
        acc_d    = acc_q;
        offset_d = offset_q;
        if (comm.step) begin
            offset_d = comm.dir_fwd ? '0 : OFFSET_LAST;
        end else if (interp_on) begin
            acc_d = acc_sum;
            if (acc_sum >= acc_period) begin
                // At most one count per clock on very short periods
                acc_d = (acc_left >= acc_period) ? '0 : acc_left;
                if (!at_limit) begin
                    offset_d = comm.dir_fwd ? offset_q + 1'b1 : offset_q - 1'b1;
                end
            end
        end
        if (comm.step || speed.new_period) begin
            acc_d = '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_q    <= '0;
            offset_q <= '0;
            angle_q  <= '0;
        end else begin
            acc_q    <= acc_d;
            offset_q <= offset_d;
            angle_q  <= sector_base + angle_t'(offset_d);
        end
    end

    // Rotor state bundle
    assign rotor.angle    = angle_q;
    assign rotor.position = position;
    assign rotor.period   = speed.period;
    assign rotor.sector   = comm.sector;
    assign rotor.dir_fwd  = comm.dir_fwd;
    assign rotor.stalled  = speed.stalled;
    assign rotor.fault    = comm.fault;

endmodule

// File: edge_timer.sv
module edge_timer import hall_pkg::*, rotor_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  hall_sample_t sample,
    output speed_t       speed
);

    period_t count;
    logic    count_full;
    logic    timely;

    assign count_full = (count == PERIOD_MAX);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Edge to edge counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // timely marks that the previous change came before saturation
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count            <= '0;
            timely           <= 1'b0;
            speed.period     <= '0;
            speed.new_period <= 1'b0;
            speed.stalled    <= 1'b1;
        end else begin
            speed.new_period <= sample.change;
            if (sample.change) begin
                // Restart at one so the latched value equals the edge spacing
                count         <= period_t'(1);
                speed.period  <= count;
                speed.stalled <= !(timely && !count_full);
                timely        <= !count_full;
            end else if (!count_full) begin
                count <= count + 1'b1;
            end else begin
                // No edge for PERIOD_MAX clocks
                speed.stalled <= 1'b1;
                timely        <= 1'b0;
            end
        end
    end

endmodule

// File: hall_decoder.sv
module hall_decoder import hall_pkg::*, rotor_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  hall_sample_t sample,
    output commutation_t comm,
    output position_t    position
);

    sector_t new_sector;
    logic    code_valid;
    sector_t sector_fwd;
    sector_t sector_rev;

    assign new_sector = SECTOR_OF_CODE[sample.code];
    assign code_valid = (new_sector != SECTOR_INVALID);

    // Neighbours of the held sector, modulo six
    assign sector_fwd = (comm.sector == SECTOR_LAST) ? '0 : comm.sector + 1'b1;
    assign sector_rev = (comm.sector == '0) ? SECTOR_LAST : comm.sector - 1'b1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sector tracking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            comm.sector  <= '0;
            comm.dir_fwd <= 1'b1;
            comm.step    <= 1'b0;
            comm.known   <= 1'b0;
            comm.fault   <= 1'b0;
            position     <= '0;
        end else begin
            comm.step <= 1'b0;
            if (sample.change) begin
                if (!code_valid) begin
                    // 000 or 111, sector and position hold
                    comm.known <= 1'b0;
                    comm.fault <= 1'b1;
                end else if (!comm.known) begin
                    // First valid code only gives a reference
                    comm.sector <= new_sector;
                    comm.known  <= 1'b1;
                end else if (new_sector == sector_fwd) begin
                    comm.sector  <= new_sector;
                    comm.dir_fwd <= 1'b1;
                    comm.step    <= 1'b1;
                    comm.fault   <= 1'b0;
                    position     <= position + 32'sd1;
                end else if (new_sector == sector_rev) begin
                    comm.sector  <= new_sector;
                    comm.dir_fwd <= 1'b0;
                    comm.step    <= 1'b1;
                    comm.fault   <= 1'b0;
                    position     <= position - 32'sd1;
                end else begin
                    // Skipped sector, resync without a step
                    comm.sector <= new_sector;
                    comm.fault  <= 1'b1;
                end
            end
        end
    end

endmodule

// File: hall_feedback_chk.sv
module hall_feedback_chk import hall_pkg::*, rotor_pkg::*; (
    input logic         clk,
    input logic         arst_n,
    input rotor_state_t rotor
);

    timeunit 1ns;
    timeprecision 1ps;

    sector_t   sector_q;
    position_t position_q;
    position_t delta;
    logic      dir_q;

    // Previous clock view of the rotor state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sector_q   <= '0;
            position_q <= '0;
            dir_q      <= 1'b1;
        end else begin
            sector_q   <= rotor.sector;
            position_q <= rotor.position;
            dir_q      <= rotor.dir_fwd;
        end
    end

    assign delta = rotor.position - position_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Rotor state properties
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    position_step: assert property (@(posedge clk) disable iff (!arst_n)
        delta == 32'sd0 || delta == 32'sd1 || delta == -32'sd1)
        else $error("position moved by more than one step in a clock");

    // Angle lags the sector by one clock
    angle_span: assert property (@(posedge clk) disable iff (!arst_n)
        rotor.angle[15:10] == {3'b000, sector_q})
        else $error("angle left the span of its sector");

    dir_with_step: assert property (@(posedge clk) disable iff (!arst_n)
        rotor.dir_fwd != dir_q |-> delta != 32'sd0)
        else $error("direction changed without a position step");

endmodule

bind hall_feedback_top hall_feedback_chk hall_feedback_chk_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .rotor  (rotor)
);

// File: hall_feedback_top.sv
module hall_feedback_top import hall_pkg::*, rotor_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         hall_a,
    input  logic         hall_b,
    input  logic         hall_c,
    output rotor_state_t rotor
);

    hall_sample_t sample;
    commutation_t comm;
    speed_t       speed;
    position_t    position;

    hall_filter hall_filter_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .hall_a (hall_a),
        .hall_b (hall_b),
        .hall_c (hall_c),
        .sample (sample)
    );

    // Decoder and timer both follow the accepted code
    hall_decoder hall_decoder_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .sample   (sample),
        .comm     (comm),
        .position (position)
    );

    edge_timer edge_timer_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .sample (sample),
        .speed  (speed)
    );

    angle_interp angle_interp_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .comm     (comm),
        .speed    (speed),
        .position (position),
        .rotor    (rotor)
    );

endmodule

// File: hall_filter.sv
module hall_filter import hall_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         hall_a,
    input  logic         hall_b,
    input  logic         hall_c,
    output hall_sample_t sample
);

    hall_code_t    sync_1;
    hall_code_t    sync_2;
    hall_code_t    candidate;
    hall_code_t    accepted;
    filter_count_t stable_cnt;
    logic          change;

    // Two-stage synchronizer on the whole code
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_1 <= '0;
            sync_2 <= '0;
        end else begin
            sync_1 <= {hall_a, hall_b, hall_c};
            sync_2 <= sync_1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stability counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Any difference restarts the count on the new candidate
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            candidate  <= '0;
            stable_cnt <= '0;
        end else if (sync_2 != candidate) begin
            candidate  <= sync_2;
            stable_cnt <= filter_count_t'(1);
        end else if (stable_cnt != FILTER_DONE) begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    // Accept a stable candidate once
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            accepted <= '0;
            change   <= 1'b0;
        end else begin
            change <= 1'b0;
            if (stable_cnt == FILTER_DONE && candidate != accepted) begin
                accepted <= candidate;
                change   <= 1'b1;
            end
        end
    end

    assign sample.code   = accepted;
    assign sample.change = change;

endmodule

// File: hall_pkg.sv
package hall_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Hall codes and sectors
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Hall lines a, b, c from msb to lsb
    typedef logic [2:0] hall_code_t;
    typedef logic [2:0] sector_t;

    localparam int      SECTOR_COUNT   = 6;
    localparam sector_t SECTOR_LAST    = sector_t'(SECTOR_COUNT - 1);
    localparam sector_t SECTOR_INVALID = 3'd7;

    // Indexed by code, forward order is 001 011 010 110 100 101
    localparam sector_t SECTOR_OF_CODE [8] = '{
        SECTOR_INVALID,  // 000
        3'd0,            // 001
        3'd2,            // 010
        3'd1,            // 011
        3'd4,            // 100
        3'd5,            // 101
        3'd3,            // 110
        SECTOR_INVALID   // 111
    };

    // Deglitch filter
    localparam int FILTER_CYCLES = 4;
    localparam int FILTER_CNT_W  = $clog2(FILTER_CYCLES + 1);

    typedef logic [FILTER_CNT_W-1:0] filter_count_t;

    localparam filter_count_t FILTER_DONE = filter_count_t'(FILTER_CYCLES);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sensor side bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        hall_code_t code;
        logic       change;
    } hall_sample_t;

    typedef struct packed {
        sector_t sector;
        logic    dir_fwd;
        logic    step;
        logic    known;
        logic    fault;
    } commutation_t;

endpackage

// File: rotor_pkg.sv
package rotor_pkg;

    import hall_pkg::sector_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Rotor estimate types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One electrical turn is six sectors of 6144 counts total
    typedef logic [15:0]        angle_t;
    typedef logic signed [31:0] position_t;
    typedef logic [15:0]        period_t;

    localparam int      SECTOR_SPAN = 1024;
    localparam period_t PERIOD_MAX  = 16'hffff;

    // In-sector offset and rate accumulator
    localparam int OFFSET_BITS = $clog2(SECTOR_SPAN);

    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [16:0]            acc_t;

    localparam offset_t OFFSET_LAST = offset_t'(SECTOR_SPAN - 1);

    typedef struct packed {
        period_t period;
        logic    new_period;
        logic    stalled;
    } speed_t;

    typedef struct packed {
        angle_t    angle;
        position_t position;
        period_t   period;
        sector_t   sector;
        logic      dir_fwd;
        logic      stalled;
        logic      fault;
    } rotor_state_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build and run the hall feedback testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_hall_feedback -f src.f -o sim_hall_feedback
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_hall_feedback > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Test OK$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// File: src.f
hall_pkg.sv
rotor_pkg.sv
hall_filter.sv
hall_decoder.sv
edge_timer.sv
angle_interp.sv
hall_feedback_top.sv
hall_feedback_chk.sv
tb_hall_feedback.sv

// File: tb_hall_feedback.sv
module tb_hall_feedback import hall_pkg::*, rotor_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SETTLE_CYCLES = FILTER_CYCLES + 5;
    localparam int TEST_CYCLES   = 1000 + 1000 + 200 + 200 + 2400 + 700;
    localparam int WATCH_CYCLES  = TEST_CYCLES + 65536 + 2000;

    // Forward order of the hall codes, sector n at index n
    localparam hall_code_t FWD_CODES [6] = '{3'b001, 3'b011, 3'b010, 3'b110, 3'b100, 3'b101};

    logic         clk;
    logic         arst_n;
    logic         hall_a;
    logic         hall_b;
    logic         hall_c;
    rotor_state_t rotor;

    int        errors = 0;
    int        seed = 32'hb9cb2ff8;
    int        cur_idx = 0;
    sector_t   exp_sector = '0;
    position_t exp_pos = '0;
    logic      exp_dir = 1'b1;
    logic      exp_fault = 1'b0;
    logic      exp_known = 1'b0;

    hall_feedback_top hall_feedback_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .hall_a (hall_a),
        .hall_b (hall_b),
        .hall_c (hall_c),
        .rotor  (rotor)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (WATCH_CYCLES) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("Test FAILED");
        $finish;
    end

    function automatic int sector_of(input hall_code_t code);
        int s;
        s = 7;
        for (int i = 0; i < 6; i++) begin
            if (FWD_CODES[i] == code) s = i;
        end
        return s;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic model_apply(input hall_code_t code);
        int s;
        s = sector_of(code);
        if (s == 7) begin
            exp_fault = 1'b1;
            exp_known = 1'b0;
        end else if (!exp_known) begin
            exp_sector = sector_t'(s);
            exp_known  = 1'b1;
        end else if (s == (exp_sector + 1) % 6) begin
            exp_sector = sector_t'(s);
            exp_pos++;
            exp_dir   = 1'b1;
            exp_fault = 1'b0;
        end else if (s == (exp_sector + 5) % 6) begin
            exp_sector = sector_t'(s);
            exp_pos--;
            exp_dir   = 1'b0;
            exp_fault = 1'b0;
        end else begin
            exp_sector = sector_t'(s);
            exp_fault  = 1'b1;
        end
    endtask

    task automatic drive_code(input hall_code_t code);
        @(negedge clk);
        {hall_a, hall_b, hall_c} = code;
        model_apply(code);
    endtask

    task automatic drive_step(input bit fwd);
        cur_idx = fwd ? (cur_idx + 1) % 6 : (cur_idx + 5) % 6;
        drive_code(FWD_CODES[cur_idx]);
    endtask

    task automatic settle();
        repeat (SETTLE_CYCLES) @(negedge clk);
    endtask

    task automatic check_state();
        assert (rotor.position == exp_pos) else begin
            errors++;
            $display("** Error: position expected %h actual %h", exp_pos, rotor.position);
        end
        assert (rotor.sector == exp_sector) else begin
            errors++;
            $display("** Error: sector expected %h actual %h", exp_sector, rotor.sector);
        end
        assert (rotor.dir_fwd == exp_dir) else begin
            errors++;
            $display("** Error: dir_fwd expected %h actual %h", exp_dir, rotor.dir_fwd);
        end
        assert (rotor.fault == exp_fault) else begin
            errors++;
            $display("** Error: fault expected %h actual %h", exp_fault, rotor.fault);
        end
    endtask

    task automatic check_period(input int n);
        assert (rotor.period == period_t'(n)) else begin
            errors++;
            $display("** Error: period expected %h actual %h", n, rotor.period);
        end
        assert (rotor.stalled == 1'b0) else begin
            errors++;
            $display("** Error: stalled expected %h actual %h", 1'b0, rotor.stalled);
        end
    endtask

    // One step with the next one n clocks later, angle watched in between
    task automatic step_timed(input bit fwd, input int n);
        int        used;
        position_t pos0;
        angle_t    base;
        angle_t    start;
        angle_t    prev;
        pos0 = rotor.position;
        drive_step(fwd);
        used = 0;
        while (rotor.position == pos0 && used < 20) begin
            @(negedge clk);
            used++;
        end
        assert (rotor.position != pos0) else begin
            errors++;
            $display("Position did not move after a step");
        end
        @(negedge clk);
        used++;
        base  = angle_t'(exp_sector) * angle_t'(SECTOR_SPAN);
        start = fwd ? base : base + angle_t'(SECTOR_SPAN - 1);
        assert (rotor.angle == start) else begin
            errors++;
            $display("** Error: angle expected %h actual %h", start, rotor.angle);
        end
        prev = rotor.angle;
        while (used < n - 1) begin
            @(negedge clk);
            used++;
            assert (fwd ? rotor.angle >= prev : rotor.angle <= prev) else begin
                errors++;
                $display("** Error: angle moved back from %h to %h", prev, rotor.angle);
            end
            assert (rotor.angle >= base && rotor.angle < base + angle_t'(SECTOR_SPAN)) else begin
                errors++;
                $display("** Error: angle base %h actual %h", base, rotor.angle);
            end
            prev = rotor.angle;
        end
        check_state();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic test_forward();
        int gap;
        cur_idx = 0;
        drive_code(FWD_CODES[0]);
        settle();
        check_state();
        for (int i = 0; i < 12; i++) begin
            gap = 20 + ($unsigned($random(seed)) % 20);
            drive_step(1'b1);
            settle();
            check_state();
            repeat (gap - SETTLE_CYCLES) @(negedge clk);
        end
    endtask

    task automatic test_reverse();
        int gap;
        for (int i = 0; i < 12; i++) begin
            gap = 20 + ($unsigned($random(seed)) % 20);
            drive_step(1'b0);
            settle();
            check_state();
            repeat (gap - SETTLE_CYCLES) @(negedge clk);
        end
    endtask

    task automatic test_glitch();
        hall_code_t code;
        code = FWD_CODES[cur_idx];
        for (int line = 0; line < 3; line++) begin
            for (int len = 1; len < FILTER_CYCLES; len++) begin
                @(negedge clk);
                {hall_a, hall_b, hall_c} = code ^ hall_code_t'(1 << line);
                repeat (len) @(negedge clk);
                {hall_a, hall_b, hall_c} = code;
                // A step and its undo would cancel out by the end
                repeat (SETTLE_CYCLES) begin
                    @(negedge clk);
                    assert (rotor.position == exp_pos) else begin
                        errors++;
                        $display("** Error: position expected %h actual %h",
                                 exp_pos, rotor.position);
                    end
                end
                check_state();
            end
        end
    endtask

    task automatic test_faults();
        drive_code(3'b000);
        settle();
        check_state();
        drive_code(FWD_CODES[cur_idx]);
        settle();
        drive_code(3'b111);
        settle();
        check_state();
        drive_code(FWD_CODES[cur_idx]);
        settle();
        check_state();
        cur_idx = (cur_idx + 2) % 6;
        drive_code(FWD_CODES[cur_idx]);
        settle();
        check_state();
        drive_step(1'b1);
        settle();
        check_state();
    endtask

    task automatic test_period_angle();
        int spans [3] = '{40, 100, 250};
        foreach (spans[i]) begin
            for (int k = 0; k < 3; k++) begin
                step_timed(1'b1, spans[i]);
                if (k > 0) check_period(spans[i]);
            end
        end
        for (int k = 0; k < 3; k++) begin
            step_timed(1'b0, 60);
            if (k > 0) check_period(60);
        end
    endtask

    task automatic test_stall();
        angle_t held;
        angle_t base;
        repeat (65540) @(negedge clk);
        assert (rotor.stalled == 1'b1) else begin
            errors++;
            $display("** Error: stalled expected %h actual %h", 1'b1, rotor.stalled);
        end
        held = rotor.angle;
        repeat (50) @(negedge clk);
        assert (rotor.angle == held) else begin
            errors++;
            $display("** Error: angle expected %h actual %h", held, rotor.angle);
        end
        // First step after the stall sees a saturated count, angle stays at the sector start
        step_timed(1'b1, 200);
        base = angle_t'(exp_sector) * angle_t'(SECTOR_SPAN);
        assert (rotor.stalled == 1'b1) else begin
            errors++;
            $display("** Error: stalled expected %h actual %h", 1'b1, rotor.stalled);
        end
        assert (rotor.angle == base) else begin
            errors++;
            $display("** Error: angle expected %h actual %h", base, rotor.angle);
        end
        // Two timely steps follow
        for (int k = 0; k < 2; k++) step_timed(1'b1, 200);
        check_period(200);
        assert (rotor.angle[9:0] != 10'd0) else begin
            errors++;
            $display("Angle did not interpolate after the stall ended");
        end
    endtask

    initial begin
        arst_n = 1'b0;
        hall_a = 1'b0;
        hall_b = 1'b0;
        hall_c = 1'b0;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        repeat (2) @(negedge clk);
        test_forward();
        test_reverse();
        test_glitch();
        test_faults();
        test_period_angle();
        test_stall();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
